//--- src/core_pkg.sv
/*
 * Core definitions for the blimp RV32I subset core
 * Opcodes, register and word types, control states and the retire trace
 */

package core_pkg;

  // ------------------------------------------------------------------------
  // Basic types
  // ------------------------------------------------------------------------

  // Architectural data word
  typedef logic [31:0] word_t;

  // Register file index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // ------------------------------------------------------------------------
  // ISA encodings
  // ------------------------------------------------------------------------

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  // ------------------------------------------------------------------------
  // Control and trace
  // ------------------------------------------------------------------------

  // Multicycle control states, one instruction in flight
  typedef enum logic [2:0] {
    FETCH,
    WAIT_INST,
    EXECUTE,
    MEM,
    WAIT_MEM,
    RETIRE
  } ctrl_state_t;

  // One entry per retired instruction, 71 bits
  typedef struct packed {
    word_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
    logic     val;
  } trace_t;

endpackage

//--- src/mem_pkg.sv
/*
 * Memory bus definitions
 * Request and response layout shared by the requesters, arbiter and memory
 */

package mem_pkg;

  // Byte address, low two bits ignored by the memory
  typedef logic [31:0] mem_addr_t;

  // Bus data word
  typedef logic [31:0] mem_data_t;

  // Memory depth in words
  localparam int MEM_WORDS = 1024;
  localparam int IDX_BITS  = $clog2(MEM_WORDS);

  // Word index into the array
  typedef logic [IDX_BITS-1:0] mem_idx_t;

  // Request held by a requester until granted
  typedef struct packed {
    logic      req;
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
  } mem_req_t;

  // Read data, one cycle after the grant
  typedef struct packed {
    logic      val;
    mem_data_t rdata;
  } mem_resp_t;

  // Owner of an outstanding read
  typedef enum logic [1:0] {
    REQ_BOOT,
    REQ_LSU,
    REQ_FETCH
  } requester_t;

endpackage

//--- src/fetch_unit.sv
/*
 * Instruction fetch unit
 * Holds the pc, reads instruction words through the arbiter, latches them
 */

`timescale 1ns/10ps

module fetch_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetch,
  input  core_pkg::word_t    next_pc,
  input  logic               pc_load,
  output core_pkg::word_t    pc,
  output mem_pkg::mem_req_t  mem_req,
  input  logic               grant,
  input  mem_pkg::mem_resp_t mem_resp,
  output logic               inst_val,
  output core_pkg::word_t    inst
);

  core_pkg::word_t pc_q;
  core_pkg::word_t inst_q;
  logic            pending_q;

  // Strobe goes out at once, pending keeps it up until granted
  assign mem_req.req   = fetch | pending_q;
  assign mem_req.we    = 1'b0;
  assign mem_req.addr  = pc_q;
  assign mem_req.wdata = '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_q <= 1'b0;
      pc_q      <= core_pkg::RESET_PC;
    end else begin
      if (grant) begin
        pending_q <= 1'b0;
      end else if (fetch) begin
        pending_q <= 1'b1;
      end
      // Redirect at retirement
      if (pc_load) begin
        pc_q <= next_pc;
      end
    end
  end

  // Instruction word stays put for the rest of the instruction
  always_ff @(posedge clk) begin
    if (mem_resp.val) begin
      inst_q <= mem_resp.rdata;
    end
  end

  assign pc       = pc_q;
  assign inst     = inst_q;
  assign inst_val = mem_resp.val;

  // Core waits for the word before it fetches again
  a_no_refetch: assert property (@(posedge clk) disable iff (reset)
    pending_q |-> !fetch);

endmodule

//--- src/load_store_unit.sv
/*
 * Load/store unit
 * Issues one word access per strobe and reports completion to the core
 */

`timescale 1ns/10ps

module load_store_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               we,
  input  core_pkg::word_t    addr,
  input  core_pkg::word_t    wdata,
  output mem_pkg::mem_req_t  mem_req,
  input  logic               grant,
  input  mem_pkg::mem_resp_t mem_resp,
  output logic               done,
  output core_pkg::word_t    rdata
);

  logic            pending_q;
  logic            we_q;
  core_pkg::word_t addr_q;
  core_pkg::word_t wdata_q;

  // Start cycle uses the core's values directly, later cycles the copy
  assign mem_req.req   = start | pending_q;
  assign mem_req.we    = start ? we : we_q;
  assign mem_req.addr  = start ? addr : addr_q;
  assign mem_req.wdata = start ? wdata : wdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (grant) begin
      pending_q <= 1'b0;
    end else if (start) begin
      pending_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      we_q    <= we;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // Store ends at its grant, load when the data comes back
  assign done  = (grant & mem_req.we) | mem_resp.val;
  assign rdata = mem_resp.rdata;

  a_word_aligned: assert property (@(posedge clk) disable iff (reset)
    start |-> (addr[1:0] == 2'b00));

endmodule

//--- src/mem_arbiter.sv
/*
 * Fixed-priority memory arbiter
 * Boot, then load/store, then fetch share the single memory port
 */

`timescale 1ns/10ps

module mem_arbiter (
  input  logic                clk,
  input  logic                reset,
  input  mem_pkg::mem_req_t   boot_req,
  input  mem_pkg::mem_req_t   lsu_req,
  input  mem_pkg::mem_req_t   fetch_req,
  output logic                boot_grant,
  output logic                lsu_grant,
  output logic                fetch_grant,
  output mem_pkg::mem_resp_t  lsu_resp,
  output mem_pkg::mem_resp_t  fetch_resp,
  output mem_pkg::mem_req_t   mem_req,
  input  mem_pkg::mem_resp_t  mem_resp
);

  mem_pkg::requester_t winner;
  mem_pkg::requester_t owner_q;

  // ------------------------------------------------------------------------
  // Grant and forward, same cycle
  // ------------------------------------------------------------------------

  always_comb begin
    boot_grant  = boot_req.req;
    lsu_grant   = lsu_req.req && !boot_req.req;
    fetch_grant = fetch_req.req && !boot_req.req && !lsu_req.req;
    winner      = mem_pkg::REQ_FETCH;
    mem_req     = '0;
    if (boot_grant) begin
      winner  = mem_pkg::REQ_BOOT;
      mem_req = boot_req;
    end else if (lsu_grant) begin
      winner  = mem_pkg::REQ_LSU;
      mem_req = lsu_req;
    end else if (fetch_grant) begin
      mem_req = fetch_req;
    end
  end

  // ------------------------------------------------------------------------
  // Response routing
  // ------------------------------------------------------------------------

  // Remember who issued the read, data returns next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      owner_q <= mem_pkg::REQ_BOOT;
    end else if (mem_req.req && !mem_req.we) begin
      owner_q <= winner;
    end
  end

  // Boot reads have no return path and are dropped
  assign lsu_resp.val     = mem_resp.val && (owner_q == mem_pkg::REQ_LSU);
  assign lsu_resp.rdata   = mem_resp.rdata;
  assign fetch_resp.val   = mem_resp.val && (owner_q == mem_pkg::REQ_FETCH);
  assign fetch_resp.rdata = mem_resp.rdata;

  // Read data only ever follows a read granted the cycle before
  a_resp_follows_read: assert property (@(posedge clk) disable iff (reset)
    mem_resp.val |-> $past(mem_req.req && !mem_req.we));

endmodule

//--- src/unified_mem.sv
/*
 * Unified word memory
 * Single port, writes in the request cycle, read data one cycle later
 */

`timescale 1ns/10ps

module unified_mem (
  input  logic               clk,
  input  mem_pkg::mem_req_t  req,
  output mem_pkg::mem_resp_t resp
);

  mem_pkg::mem_data_t mem [mem_pkg::MEM_WORDS];
  mem_pkg::mem_idx_t  idx;
  logic               rd_en;
  logic               wr_en;

  // Word index, address bits 11 down to 2
  assign idx   = req.addr[mem_pkg::IDX_BITS+1:2];
  assign rd_en = req.req && !req.we;
  assign wr_en = req.req && req.we;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[idx] <= req.wdata;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    resp.val <= rd_en;
    if (rd_en) begin
      resp.rdata <= mem[idx];
    end
  end

endmodule

//--- src/core_ctrl.sv
/*
 * Core control and datapath
 * Decode, register file, ALU and branch logic under a multicycle FSM,
 * one trace entry per retired instruction
 */

`timescale 1ns/10ps

module core_ctrl (
  input  logic              clk,
  input  logic              reset,
  output logic              fetch,
  output core_pkg::word_t   next_pc,
  output logic              pc_load,
  input  core_pkg::word_t   pc,
  input  logic              inst_val,
  input  core_pkg::word_t   inst,
  output logic              lsu_start,
  output logic              lsu_we,
  output core_pkg::word_t   lsu_addr,
  output core_pkg::word_t   lsu_wdata,
  input  logic              lsu_done,
  input  core_pkg::word_t   lsu_rdata,
  output core_pkg::trace_t  trace
);

  core_pkg::ctrl_state_t state_q;
  core_pkg::ctrl_state_t state_d;
  logic                  run_q;
  logic                  mem_done_q;

  core_pkg::word_t       rf [32];
  core_pkg::word_t       wb_data_q;
  core_pkg::word_t       npc_q;

  core_pkg::opcode_t     op;
  core_pkg::reg_idx_t    rd;
  core_pkg::reg_idx_t    rs1;
  core_pkg::reg_idx_t    rs2;
  core_pkg::word_t       rs1_val;
  core_pkg::word_t       rs2_val;
  core_pkg::word_t       imm_i;
  core_pkg::word_t       imm_s;
  core_pkg::word_t       imm_b;
  core_pkg::word_t       imm_j;
  core_pkg::word_t       imm_u;
  core_pkg::word_t       pc_plus4;
  core_pkg::word_t       agu;
  core_pkg::word_t       result;
  core_pkg::word_t       npc;
  logic                  writes_rd;
  logic                  is_load;
  logic                  is_store;

  // ------------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------------

  assign op  = core_pkg::opcode_t'(inst[6:0]);
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  // x0 reads as zero, its entry is never written
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  assign is_load  = (op == core_pkg::OP_LOAD);
  assign is_store = (op == core_pkg::OP_STORE);

  // ------------------------------------------------------------------------
  // ALU and next pc
  // ------------------------------------------------------------------------

  assign pc_plus4 = pc + 32'd4;
  assign agu      = rs1_val + (is_store ? imm_s : imm_i);

  always_comb begin
    result    = '0;
    writes_rd = 1'b1;
    npc       = pc_plus4;
    case (op)
      core_pkg::OP_LUI:  result = imm_u;
      core_pkg::OP_IMM:  result = rs1_val + imm_i;
      // inst[30] picks SUB over ADD
      core_pkg::OP_REG:  result = inst[30] ? rs1_val - rs2_val : rs1_val + rs2_val;
      core_pkg::OP_LOAD: result = agu;
      core_pkg::OP_JAL: begin
        result = pc_plus4;
        npc    = pc + imm_j;
      end
      core_pkg::OP_BRANCH: begin
        // BEQ only
        writes_rd = 1'b0;
        if (rs1_val == rs2_val) begin
          npc = pc + imm_b;
        end
      end
      // Stores and unknown opcodes write nothing
      default: writes_rd = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::FETCH:     if (fetch) state_d = core_pkg::WAIT_INST;
      core_pkg::WAIT_INST: if (inst_val) state_d = core_pkg::EXECUTE;
      core_pkg::EXECUTE:   state_d = (is_load || is_store) ? core_pkg::MEM : core_pkg::RETIRE;
      core_pkg::MEM:       state_d = core_pkg::WAIT_MEM;
      core_pkg::WAIT_MEM:  if (lsu_done || mem_done_q) state_d = core_pkg::RETIRE;
      default:             state_d = core_pkg::FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= core_pkg::FETCH;
      run_q      <= 1'b0;
      mem_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // First fetch waits one cycle past reset
      run_q   <= 1'b1;
      // Store granted in MEM already finished
      if (state_q == core_pkg::MEM) begin
        mem_done_q <= lsu_done;
      end
    end
  end

  // Results, pc redirect and register write
  always_ff @(posedge clk) begin
    if (state_q == core_pkg::EXECUTE) begin
      wb_data_q <= result;
      npc_q     <= npc;
    end
    if (state_q == core_pkg::WAIT_MEM && lsu_done && is_load) begin
      wb_data_q <= lsu_rdata;
    end
    if (state_q == core_pkg::RETIRE && writes_rd && rd != '0) begin
      rf[rd] <= wb_data_q;
    end
  end

  assign fetch     = (state_q == core_pkg::FETCH) && run_q;
  assign pc_load   = (state_q == core_pkg::RETIRE);
  assign next_pc   = npc_q;
  assign lsu_start = (state_q == core_pkg::MEM);
  assign lsu_we    = is_store;
  assign lsu_addr  = agu;
  assign lsu_wdata = rs2_val;

  // Trace of the retiring instruction
  assign trace.pc    = pc;
  assign trace.waddr = rd;
  assign trace.wdata = wb_data_q;
  assign trace.wen   = writes_rd;
  assign trace.val   = (state_q == core_pkg::RETIRE);

  a_trace_single: assert property (@(posedge clk) disable iff (reset)
    trace.val |=> !trace.val);

endmodule

//--- src/blimp_core_top.sv
/*
 * Blimp core subsystem top
 * Core blocks, arbiter and unified memory with an outside boot write port
 */

`timescale 1ns/10ps

module blimp_core_top (
  input  logic              clk,
  input  logic              reset,
  input  mem_pkg::mem_req_t boot,
  output logic              boot_grant,
  output core_pkg::trace_t  trace
);

  // Core side
  logic               fetch;
  logic               pc_load;
  logic               inst_val;
  core_pkg::word_t    next_pc;
  core_pkg::word_t    pc;
  core_pkg::word_t    inst;
  logic               lsu_start;
  logic               lsu_we;
  logic               lsu_done;
  core_pkg::word_t    lsu_addr;
  core_pkg::word_t    lsu_wdata;
  core_pkg::word_t    lsu_rdata;

  // Bus side
  mem_pkg::mem_req_t  fetch_req;
  mem_pkg::mem_req_t  lsu_req;
  mem_pkg::mem_req_t  mem_req;
  mem_pkg::mem_resp_t fetch_resp;
  mem_pkg::mem_resp_t lsu_resp;
  mem_pkg::mem_resp_t mem_resp;
  logic               fetch_grant;
  logic               lsu_grant;

  fetch_unit u_fetch (.clk, .reset, .fetch, .next_pc, .pc_load, .pc,
    .mem_req(fetch_req), .grant(fetch_grant), .mem_resp(fetch_resp), .inst_val, .inst);

  load_store_unit u_lsu (.clk, .reset, .start(lsu_start), .we(lsu_we), .addr(lsu_addr),
    .wdata(lsu_wdata), .mem_req(lsu_req), .grant(lsu_grant), .mem_resp(lsu_resp),
    .done(lsu_done), .rdata(lsu_rdata));

  core_ctrl u_ctrl (.clk, .reset, .fetch, .next_pc, .pc_load, .pc, .inst_val, .inst,
    .lsu_start, .lsu_we, .lsu_addr, .lsu_wdata, .lsu_done, .lsu_rdata, .trace);

  mem_arbiter u_arb (.clk, .reset, .boot_req(boot), .lsu_req, .fetch_req, .boot_grant,
    .lsu_grant, .fetch_grant, .lsu_resp, .fetch_resp, .mem_req, .mem_resp);

  unified_mem u_mem (.clk, .req(mem_req), .resp(mem_resp));

endmodule

//--- verification/blimp_core_tb.sv
/*
 * Testbench for the blimp core subsystem
 * Boots small programs through the boot port and checks the retire trace
 */

`timescale 1ns/10ps

module blimp_core_tb;

  localparam int TIMEOUT   = 200;
  localparam int NOISE_MAX = 8;
  localparam int NUM_TESTS = 6;
  localparam int CONTEND   = 4;
  localparam int READBACK  = 5;

  // One program word
  typedef struct packed {
    int              prog;
    core_pkg::word_t addr;
    core_pkg::word_t data;
  } inst_entry_t;

  // One expected retirement
  typedef struct packed {
    int                 prog;
    core_pkg::word_t    pc;
    core_pkg::reg_idx_t waddr;
    core_pkg::word_t    wdata;
    logic               wen;
  } exp_entry_t;

  logic              clk;
  logic              reset;
  mem_pkg::mem_req_t boot;
  logic              boot_grant;
  core_pkg::trace_t  trace;

  inst_entry_t     inst_tab [$];
  exp_entry_t      exp_tab [$];
  string           test_name [NUM_TESTS];
  core_pkg::word_t noise_data [$];

  integer seed;
  int     errors;
  int     test_errors;
  int     passed;
  int     failed;
  logic   noise_on;
  logic   noise_grant;
  int     noise_gap;

  blimp_core_top UUT (
    .clk        (clk),
    .reset      (reset),
    .boot       (boot),
    .boot_grant (boot_grant),
    .trace      (trace)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Instruction encoders, RV32I formats
  // --------------------------------------------------------------------------

  function automatic core_pkg::word_t enc_lui(input int rd, input int imm20);
    logic [31:0] v;
    v = imm20;
    return {v[19:0], rd[4:0], core_pkg::OP_LUI};
  endfunction

  function automatic core_pkg::word_t enc_addi(input int rd, input int rs1, input int imm);
    logic [31:0] v;
    v = imm;
    return {v[11:0], rs1[4:0], 3'b000, rd[4:0], core_pkg::OP_IMM};
  endfunction

  // ADD, or SUB with funct7 bit 5 set
  function automatic core_pkg::word_t enc_alu(input int rd, input int rs1, input int rs2,
                                              input logic sub);
    return {sub ? 7'b0100000 : 7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0],
            core_pkg::OP_REG};
  endfunction

  function automatic core_pkg::word_t enc_lw(input int rd, input int rs1, input int imm);
    logic [31:0] v;
    v = imm;
    return {v[11:0], rs1[4:0], 3'b010, rd[4:0], core_pkg::OP_LOAD};
  endfunction

  function automatic core_pkg::word_t enc_sw(input int rs2, input int rs1, input int imm);
    logic [31:0] v;
    v = imm;
    return {v[11:5], rs2[4:0], rs1[4:0], 3'b010, v[4:0], core_pkg::OP_STORE};
  endfunction

  function automatic core_pkg::word_t enc_beq(input int rs1, input int rs2, input int off);
    logic [31:0] v;
    v = off;
    return {v[12], v[10:5], rs2[4:0], rs1[4:0], 3'b000, v[4:1], v[11], core_pkg::OP_BRANCH};
  endfunction

  function automatic core_pkg::word_t enc_jal(input int rd, input int off);
    logic [31:0] v;
    v = off;
    return {v[20], v[10:1], v[11], v[19:12], rd[4:0], core_pkg::OP_JAL};
  endfunction

  // --------------------------------------------------------------------------
  // Program table
  // --------------------------------------------------------------------------

  task automatic add_inst(input int prog, input core_pkg::word_t addr,
                          input core_pkg::word_t data);
    inst_entry_t e;
    e.prog = prog;
    e.addr = addr;
    e.data = data;
    inst_tab.push_back(e);
  endtask

  task automatic add_exp(input int prog, input core_pkg::word_t pc, input int waddr,
                         input core_pkg::word_t wdata, input logic wen);
    exp_entry_t e;
    e.prog  = prog;
    e.pc    = pc;
    e.waddr = waddr[4:0];
    e.wdata = wdata;
    e.wen   = wen;
    exp_tab.push_back(e);
  endtask

  task automatic build_programs();
    // ALU ops in program order
    add_inst(0, 32'h00, enc_lui(1, 'h12345));
    add_inst(0, 32'h04, enc_addi(2, 1, 'h678));
    add_inst(0, 32'h08, enc_addi(3, 0, -5));
    add_inst(0, 32'h0c, enc_alu(4, 2, 3, 1'b0));
    add_inst(0, 32'h10, enc_alu(5, 2, 3, 1'b1));
    add_inst(0, 32'h14, enc_jal(0, 0));
    add_exp(0, 32'h00, 1, 32'h1234_5000, 1'b1);
    add_exp(0, 32'h04, 2, 32'h1234_5678, 1'b1);
    add_exp(0, 32'h08, 3, 32'hffff_fffb, 1'b1);
    add_exp(0, 32'h0c, 4, 32'h1234_5673, 1'b1);
    add_exp(0, 32'h10, 5, 32'h1234_567d, 1'b1);
    // Store then load back from 0x108
    add_inst(1, 32'h00, enc_addi(1, 0, 'h100));
    add_inst(1, 32'h04, enc_lui(2, 'hcafe0));
    add_inst(1, 32'h08, enc_addi(2, 2, 'h5a5));
    add_inst(1, 32'h0c, enc_sw(2, 1, 8));
    add_inst(1, 32'h10, enc_lw(3, 1, 8));
    add_inst(1, 32'h14, enc_alu(4, 3, 1, 1'b0));
    add_inst(1, 32'h18, enc_jal(0, 0));
    add_exp(1, 32'h00, 1, 32'h0000_0100, 1'b1);
    add_exp(1, 32'h04, 2, 32'hcafe_0000, 1'b1);
    add_exp(1, 32'h08, 2, 32'hcafe_05a5, 1'b1);
    add_exp(1, 32'h0c, 0, 32'h0, 1'b0);
    add_exp(1, 32'h10, 3, 32'hcafe_05a5, 1'b1);
    add_exp(1, 32'h14, 4, 32'hcafe_06a5, 1'b1);
    // Taken BEQ, not taken BEQ, JAL with link
    add_inst(2, 32'h00, enc_addi(1, 0, 7));
    add_inst(2, 32'h04, enc_addi(2, 0, 7));
    add_inst(2, 32'h08, enc_beq(1, 2, 8));
    add_inst(2, 32'h0c, enc_addi(3, 0, 1));
    add_inst(2, 32'h10, enc_beq(1, 0, 8));
    add_inst(2, 32'h14, enc_jal(5, 12));
    add_inst(2, 32'h18, enc_addi(3, 0, 2));
    add_inst(2, 32'h1c, enc_addi(3, 0, 3));
    add_inst(2, 32'h20, enc_addi(6, 5, 1));
    add_inst(2, 32'h24, enc_jal(0, 0));
    add_exp(2, 32'h00, 1, 32'h7, 1'b1);
    add_exp(2, 32'h04, 2, 32'h7, 1'b1);
    add_exp(2, 32'h08, 0, 32'h0, 1'b0);
    add_exp(2, 32'h10, 0, 32'h0, 1'b0);
    add_exp(2, 32'h14, 5, 32'h18, 1'b1);
    add_exp(2, 32'h20, 6, 32'h19, 1'b1);
    // x0 writes trace the value, reads stay zero
    add_inst(3, 32'h00, enc_addi(0, 0, 'h55));
    add_inst(3, 32'h04, enc_lui(0, 'habcde));
    add_inst(3, 32'h08, enc_alu(1, 0, 0, 1'b0));
    add_inst(3, 32'h0c, enc_addi(2, 0, 3));
    add_inst(3, 32'h10, enc_jal(0, 0));
    add_exp(3, 32'h00, 0, 32'h55, 1'b1);
    add_exp(3, 32'h04, 0, 32'habcd_e000, 1'b1);
    add_exp(3, 32'h08, 1, 32'h0, 1'b1);
    add_exp(3, 32'h0c, 2, 32'h3, 1'b1);
    add_exp(3, 32'h10, 0, 32'h14, 1'b1);
    // Mixed program, run under boot write noise
    add_inst(4, 32'h00, enc_addi(1, 0, 'h100));
    add_inst(4, 32'h04, enc_addi(2, 0, 'h2a));
    add_inst(4, 32'h08, enc_sw(2, 1, 0));
    add_inst(4, 32'h0c, enc_lw(3, 1, 0));
    add_inst(4, 32'h10, enc_alu(4, 3, 2, 1'b0));
    add_inst(4, 32'h14, enc_alu(5, 4, 1, 1'b1));
    add_inst(4, 32'h18, enc_beq(3, 2, 8));
    add_inst(4, 32'h1c, enc_addi(6, 0, 1));
    add_inst(4, 32'h20, enc_addi(7, 5, 1));
    add_inst(4, 32'h24, enc_jal(0, 0));
    add_exp(4, 32'h00, 1, 32'h100, 1'b1);
    add_exp(4, 32'h04, 2, 32'h2a, 1'b1);
    add_exp(4, 32'h08, 0, 32'h0, 1'b0);
    add_exp(4, 32'h0c, 3, 32'h2a, 1'b1);
    add_exp(4, 32'h10, 4, 32'h54, 1'b1);
    add_exp(4, 32'h14, 5, 32'hffff_ff54, 1'b1);
    add_exp(4, 32'h18, 0, 32'h0, 1'b0);
    add_exp(4, 32'h20, 7, 32'hffff_ff55, 1'b1);
  endtask

  // Reads back every noise word, x1 upward
  task automatic build_readback();
    int n;
    n = noise_data.size();
    for (int k = 0; k < n; k++) begin
      add_inst(READBACK, 32'(4 * k), enc_lw(k + 1, 0, 'h200 + 4 * k));
      add_exp(READBACK, 32'(4 * k), k + 1, noise_data[k], 1'b1);
    end
    add_inst(READBACK, 32'(4 * n), enc_jal(0, 0));
    add_exp(READBACK, 32'(4 * n), 0, 32'(4 * n + 4), 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // Boot port drive
  // --------------------------------------------------------------------------

  task automatic boot_idle();
    boot.req   = 1'b0;
    boot.we    = 1'b0;
    boot.addr  = '0;
    boot.wdata = '0;
  endtask

  task automatic check_quiet(input string name);
    if (trace.val) begin
      $display("Fail %s trace val during reset: expected 0, actual 1", name);
      test_errors++;
    end
  endtask

  // Called just after a rising edge, returns just after the write edge
  task automatic load_word(input string name, input core_pkg::word_t addr,
                           input core_pkg::word_t data);
    int waited;
    waited     = 0;
    boot.req   = 1'b1;
    boot.we    = 1'b1;
    boot.addr  = addr;
    boot.wdata = data;
    @(negedge clk);
    while (!boot_grant && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!boot_grant) begin
      $display("Timeout in %s: boot write to %h was never granted", name, addr);
      test_errors++;
    end
    check_quiet(name);
    @(posedge clk);
    #1;
    boot_idle();
  endtask

  // Noise writes to 0x200 and up, gaps of 0 to 3 cycles
  task automatic drive_contention();
    if (boot.req && !noise_grant) begin
      // Still held, arbiter has not taken it
    end else begin
      boot_idle();
      if (noise_on && noise_data.size() < NOISE_MAX) begin
        if (noise_gap > 0) begin
          noise_gap--;
        end else begin
          boot.req    = 1'b1;
          boot.we     = 1'b1;
          boot.addr   = 32'h200 + 32'(4 * noise_data.size());
          boot.wdata  = $random(seed);
          noise_data.push_back(boot.wdata);
          noise_gap   = $random(seed) & 3;
          noise_grant = 1'b0;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Trace collection and one full program run
  // --------------------------------------------------------------------------

  task automatic collect(input int prog, input string name);
    core_pkg::trace_t got;
    exp_entry_t       e;
    int               waited;
    logic             first;
    logic             stop;
    first = 1'b1;
    stop  = 1'b0;
    foreach (exp_tab[i]) begin
      if (exp_tab[i].prog == prog && !stop) begin
        e      = exp_tab[i];
        waited = 0;
        got    = '0;
        while (!got.val && waited < TIMEOUT) begin
          @(negedge clk);
          noise_grant = boot_grant;
          got         = trace;
          if (!got.val) begin
            waited++;
          end
          @(posedge clk);
          #1;
          drive_contention();
        end
        if (!got.val) begin
          $display("Timeout in %s: no instruction retired within %0d cycles", name, TIMEOUT);
          test_errors++;
          stop = 1'b1;
        end else begin
          // Fetch, wait and execute come before the first retirement
          if (first && waited < 3) begin
            $display("Fail %s first retirement latency: expected at least 3, actual %0d",
                     name, waited);
            test_errors++;
          end
          first = 1'b0;
          if (got.pc != e.pc || got.wen != e.wen ||
              (e.wen && (got.waddr != e.waddr || got.wdata != e.wdata))) begin
            $display("Fail %s: expected pc=%h waddr=%0d wdata=%h wen=%b",
                     name, e.pc, e.waddr, e.wdata, e.wen,
                     ", actual pc=%h waddr=%0d wdata=%h wen=%b",
                     got.pc, got.waddr, got.wdata, got.wen);
            test_errors++;
          end
        end
      end
    end
  endtask

  task automatic run_program(input int prog);
    string name;
    int    cycles;
    int    waited;
    name        = test_name[prog];
    test_errors = 0;
    reset       = 1'b1;
    boot_idle();
    @(posedge clk);
    #1;
    cycles = 1;
    foreach (inst_tab[i]) begin
      if (inst_tab[i].prog == prog) begin
        load_word(name, inst_tab[i].addr, inst_tab[i].data);
        cycles++;
      end
    end
    while (cycles < 5) begin
      @(negedge clk);
      check_quiet(name);
      @(posedge clk);
      #1;
      cycles++;
    end
    reset       = 1'b0;
    noise_on    = (prog == CONTEND);
    noise_gap   = 0;
    noise_grant = 1'b0;
    collect(prog, name);
    // Let an open noise write finish before the next reset
    noise_on = 1'b0;
    waited   = 0;
    while (boot.req && waited < TIMEOUT) begin
      @(negedge clk);
      noise_grant = boot_grant;
      @(posedge clk);
      #1;
      drive_contention();
      waited++;
    end
    if (boot.req) begin
      $display("Timeout in %s: boot write still waiting for its grant", name);
      test_errors++;
      boot_idle();
    end
    if (test_errors == 0) begin
      $display("%s: ok", name);
      passed++;
    end else begin
      $display("%s: %0d error(s)", name, test_errors);
      failed++;
    end
    errors += test_errors;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    seed        = 32'hbbceb804;
    reset       = 1'b1;
    noise_on    = 1'b0;
    noise_grant = 1'b0;
    noise_gap   = 0;
    errors      = 0;
    test_errors = 0;
    passed      = 0;
    failed      = 0;
    boot_idle();
    test_name[0] = "alu";
    test_name[1] = "mem";
    test_name[2] = "branch";
    test_name[3] = "x0";
    test_name[4] = "contention";
    test_name[5] = "readback";
    build_programs();
    for (int p = 0; p < NUM_TESTS; p++) begin
      if (p == READBACK) begin
        build_readback();
      end
      run_program(p);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, passed, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
src/core_pkg.sv
src/mem_pkg.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/core_ctrl.sv
src/blimp_core_top.sv
verification/blimp_core_tb.sv

//--- Makefile
# Verilator build and run for the blimp core testbench

SRCS := $(shell cat compile.f)
BIN  := obj_dir/Vblimp_core_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -sv --top-module blimp_core_tb \
	  -f compile.f --Mdir obj_dir -o Vblimp_core_tb

# Pass or fail comes from the log
run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
